//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
LOG       ?= sim.log
FILELIST  ?= core.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- core.f
core_pkg.sv
core_regfile.sv
core_dispatch.sv
core_alu.sv
core_agu.sv
core_wb_arbiter.sv
core.sv
tb_core.sv

//--- core.sv
module core #(
	parameter int DMEM_ADDR_W = 14
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  core_pkg::issue_t    i_issue,
	output logic                o_busy,
	output core_pkg::dmem_req_t o_dmem,
	input  logic [31:0]         i_dmem_rdata,
	output core_pkg::wb_t       o_wb
);
	import core_pkg::*;

	prd_t            raddr1;
	prd_t            raddr2;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;

	exec_t           ex_alu0;
	exec_t           ex_alu1;
	exec_t           ex_agu;
	logic            alu0_ready;
	logic            alu1_ready;
	logic            agu_ready;

	wb_t             req_alu0;
	wb_t             req_alu1;
	wb_t             req_agu;
	logic            grant_alu0;
	logic            grant_alu1;
	logic            grant_agu;

	core_dispatch u_dispatch (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_issue      (i_issue),
		.o_busy       (o_busy),
		.o_raddr1     (raddr1),
		.o_raddr2     (raddr2),
		.i_rdata1     (rdata1),
		.i_rdata2     (rdata2),
		.i_alu0_ready (alu0_ready),
		.i_alu1_ready (alu1_ready),
		.i_agu_ready  (agu_ready),
		.o_alu0       (ex_alu0),
		.o_alu1       (ex_alu1),
		.o_agu        (ex_agu)
	);

	// the single write port is fed by the writeback bus
	core_regfile u_regfile (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_raddr1 (raddr1),
		.i_raddr2 (raddr2),
		.o_rdata1 (rdata1),
		.o_rdata2 (rdata2),
		.i_wb     (o_wb)
	);

	core_alu u_alu0 (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_exec  (ex_alu0),
		.o_ready (alu0_ready),
		.o_req   (req_alu0),
		.i_grant (grant_alu0)
	);

	core_alu u_alu1 (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_exec  (ex_alu1),
		.o_ready (alu1_ready),
		.o_req   (req_alu1),
		.i_grant (grant_alu1)
	);

	core_agu #(
		.DMEM_ADDR_W (DMEM_ADDR_W)
	) u_agu (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_exec       (ex_agu),
		.o_ready      (agu_ready),
		.o_dmem       (o_dmem),
		.i_dmem_rdata (i_dmem_rdata),
		.o_req        (req_agu),
		.i_grant      (grant_agu)
	);

	core_wb_arbiter u_wb_arbiter (
		.i_req_agu    (req_agu),
		.i_req_alu0   (req_alu0),
		.i_req_alu1   (req_alu1),
		.o_grant_agu  (grant_agu),
		.o_grant_alu0 (grant_alu0),
		.o_grant_alu1 (grant_alu1),
		.o_wb         (o_wb)
	);

endmodule

//--- core_agu.sv
module core_agu #(
	parameter int DMEM_ADDR_W = 14
) (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  core_pkg::exec_t     i_exec,
	output logic                o_ready,
	output core_pkg::dmem_req_t o_dmem,
	input  logic [31:0]         i_dmem_rdata,
	output core_pkg::wb_t       o_req,
	input  logic                i_grant
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		AGU_IDLE,
		AGU_LOAD,
		AGU_HOLD
	} agu_state_e;

	agu_state_e             state;
	agu_state_e             state_nxt;
	logic                   take;
	logic                   is_load;
	logic                   is_store;
	logic                   data_in;
	logic [XLEN-1:0]        addr_full;
	logic [DMEM_ADDR_W-1:0] addr_q;
	logic [XLEN-1:0]        wdata_q;
	logic                   we_q;
	prd_t                   prd_q;
	logic                   req_v;
	logic [XLEN-1:0]        req_data;

	// free when idle or when the load result leaves this cycle
	assign o_ready  = (state == AGU_IDLE) || ((state == AGU_HOLD) && req_v && i_grant);
	assign take     = i_exec.valid && o_ready;
	assign is_load  = (i_exec.uop == UOP_LW);
	assign is_store = (i_exec.uop == UOP_SW);

	assign addr_full = i_exec.op1 + i_exec.imm;

	// first HOLD cycle, memory answers the load now
	assign data_in = (state == AGU_HOLD) && !req_v;

	always_comb begin
		state_nxt = state;
		case (state)
			AGU_IDLE: begin
				if (take && is_load) begin
					state_nxt = AGU_LOAD;
				end
			end
			AGU_LOAD: begin
				state_nxt = AGU_HOLD;
			end
			AGU_HOLD: begin
				if (req_v && i_grant) begin
					state_nxt = (take && is_load) ? AGU_LOAD : AGU_IDLE;
				end
			end
			default: begin
				state_nxt = AGU_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= AGU_IDLE;
			we_q  <= 1'b0;
			req_v <= 1'b0;
		end else begin
			state <= state_nxt;
			we_q  <= take && is_store;
			if (data_in) begin
				req_v <= 1'b1;
			end else if (i_grant) begin
				req_v <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (take) begin
			addr_q  <= addr_full[DMEM_ADDR_W-1:0];
			wdata_q <= i_exec.op2;
			prd_q   <= i_exec.prd;
		end
		if (data_in) begin
			req_data <= i_dmem_rdata;
		end
	end

	assign o_dmem.we    = we_q;
	assign o_dmem.addr  = XLEN'(addr_q);
	assign o_dmem.wdata = wdata_q;

	assign o_req.valid = req_v;
	assign o_req.prd   = prd_q;
	assign o_req.data  = req_data;

endmodule

//--- core_alu.sv
module core_alu (
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  core_pkg::exec_t i_exec,
	output logic            o_ready,
	output core_pkg::wb_t   o_req,
	input  logic            i_grant
);
	import core_pkg::*;

	logic            take;
	logic            advance;
	logic [XLEN-1:0] result;

	// operand stage
	logic            ex_v;
	uop_e            uop_q;
	prd_t            prd_q;
	logic [XLEN-1:0] op1_q;
	logic [XLEN-1:0] op2_q;
	logic [XLEN-1:0] imm_q;

	// result held until the bus is granted
	logic            req_v;
	prd_t            req_prd;
	logic [XLEN-1:0] req_data;

	assign advance = ex_v && (!req_v || i_grant);
	assign o_ready = !ex_v || advance;
	assign take    = i_exec.valid && o_ready;

	always_comb begin
		case (uop_q)
			UOP_ADD: result = op1_q + op2_q;
			UOP_SUB: result = op1_q - op2_q;
			UOP_AND: result = op1_q & op2_q;
			UOP_OR:  result = op1_q | op2_q;
			UOP_XOR: result = op1_q ^ op2_q;
			UOP_SLT: result = XLEN'($signed(op1_q) < $signed(op2_q));
			UOP_SLL: result = op1_q << op2_q[4:0];
			UOP_SRL: result = op1_q >> op2_q[4:0];
			UOP_LI:  result = imm_q;
			default: result = '0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ex_v  <= 1'b0;
			req_v <= 1'b0;
		end else begin
			if (take) begin
				ex_v <= 1'b1;
			end else if (advance) begin
				ex_v <= 1'b0;
			end
			if (advance) begin
				req_v <= 1'b1;
			end else if (i_grant) begin
				req_v <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (take) begin
			uop_q <= i_exec.uop;
			prd_q <= i_exec.prd;
			op1_q <= i_exec.op1;
			op2_q <= i_exec.op2;
			imm_q <= i_exec.imm;
		end
		if (advance) begin
			req_prd  <= prd_q;
			req_data <= result;
		end
	end

	assign o_req.valid = req_v;
	assign o_req.prd   = req_prd;
	assign o_req.data  = req_data;

endmodule

//--- core_dispatch.sv
module core_dispatch (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  core_pkg::issue_t i_issue,
	output logic             o_busy,
	output core_pkg::prd_t   o_raddr1,
	output core_pkg::prd_t   o_raddr2,
	input  logic [31:0]      i_rdata1,
	input  logic [31:0]      i_rdata2,
	input  logic             i_alu0_ready,
	input  logic             i_alu1_ready,
	input  logic             i_agu_ready,
	output core_pkg::exec_t  o_alu0,
	output core_pkg::exec_t  o_alu1,
	output core_pkg::exec_t  o_agu
);
	import core_pkg::*;

	logic            is_mem;
	logic            accept;
	logic            to_alu0;
	logic            to_alu1;
	logic            to_agu;
	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;
	exec_t           ex;

	// LI accepted at the last edge, value known already
	logic            li_v_q;
	prd_t            li_prd_q;
	logic [XLEN-1:0] li_imm_q;

	assign o_raddr1 = i_issue.prs1;
	assign o_raddr2 = i_issue.prs2;

	assign is_mem = uop_is_mem(i_issue.uop);

	// stall only on the pipes this uop can go to
	assign o_busy = is_mem ? !i_agu_ready : !(i_alu0_ready || i_alu1_ready);

	assign accept  = i_issue.valid && !o_busy;
	assign to_agu  = accept && is_mem;
	assign to_alu0 = accept && !is_mem && i_alu0_ready;
	assign to_alu1 = accept && !is_mem && !i_alu0_ready;

	// back-to-back reader of an LI target, regfile not written yet
	assign op1 = (li_v_q && (li_prd_q == i_issue.prs1)) ? li_imm_q : i_rdata1;
	assign op2 = (li_v_q && (li_prd_q == i_issue.prs2)) ? li_imm_q : i_rdata2;

	always_comb begin
		ex.valid = 1'b0;
		ex.uop   = i_issue.uop;
		ex.prd   = i_issue.prd;
		ex.op1   = op1;
		ex.op2   = op2;
		ex.imm   = i_issue.imm;

		o_alu0       = ex;
		o_alu0.valid = to_alu0;
		o_alu1       = ex;
		o_alu1.valid = to_alu1;
		o_agu        = ex;
		o_agu.valid  = to_agu;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			li_v_q <= 1'b0;
		end else begin
			li_v_q <= accept && (i_issue.uop == UOP_LI) && (i_issue.prd != '0);
		end
	end

	always_ff @(posedge i_clk) begin
		li_prd_q <= i_issue.prd;
		li_imm_q <= i_issue.imm;
	end

endmodule

//--- core_pkg.sv
package core_pkg;

	localparam int PRD_W   = 7;
	localparam int NUM_PRD = 128;
	localparam int XLEN    = 32;

	// micro-op encoding as seen by the back end
	typedef enum logic [3:0] {
		UOP_ADD,
		UOP_SUB,
		UOP_AND,
		UOP_OR,
		UOP_XOR,
		UOP_SLT,
		UOP_SLL,
		UOP_SRL,
		UOP_LI,
		UOP_LW,
		UOP_SW
	} uop_e;

	typedef logic [PRD_W-1:0] prd_t;

	// renamed micro-op from the issue side
	typedef struct packed {
		logic            valid;
		uop_e            uop;
		prd_t            prd;
		prd_t            prs1;
		prd_t            prs2;
		logic [XLEN-1:0] imm;
	} issue_t;

	// operands already read
	typedef struct packed {
		logic            valid;
		uop_e            uop;
		prd_t            prd;
		logic [XLEN-1:0] op1;
		logic [XLEN-1:0] op2;
		logic [XLEN-1:0] imm;
	} exec_t;

	typedef struct packed {
		logic            valid;
		prd_t            prd;
		logic [XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic            we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} dmem_req_t;

	function automatic logic uop_is_mem(uop_e uop);
		return (uop == UOP_LW) || (uop == UOP_SW);
	endfunction

endpackage

//--- core_regfile.sv
module core_regfile (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  core_pkg::prd_t i_raddr1,
	input  core_pkg::prd_t i_raddr2,
	output logic [31:0]    o_rdata1,
	output logic [31:0]    o_rdata2,
	input  core_pkg::wb_t  i_wb
);
	import core_pkg::*;

	logic [XLEN-1:0] mem [NUM_PRD];
	logic            we;

	// p0 is hardwired to zero
	assign we = i_wb.valid && (i_wb.prd != '0);

	// no writes while the core is held in reset
	always_ff @(posedge i_clk) begin
		if (i_rst_n && we) begin
			mem[i_wb.prd] <= i_wb.data;
		end
	end

	function automatic logic [XLEN-1:0] read_port(
		prd_t            addr,
		wb_t             wb,
		logic [XLEN-1:0] word
	);
		logic [XLEN-1:0] val;
		if (addr == '0) begin
			val = '0;
		end else if (wb.valid && (wb.prd == addr)) begin
			// write in flight this cycle
			val = wb.data;
		end else begin
			val = word;
		end
		return val;
	endfunction

	assign o_rdata1 = read_port(i_raddr1, i_wb, mem[i_raddr1]);
	assign o_rdata2 = read_port(i_raddr2, i_wb, mem[i_raddr2]);

endmodule

//--- core_wb_arbiter.sv
module core_wb_arbiter (
	input  core_pkg::wb_t i_req_agu,
	input  core_pkg::wb_t i_req_alu0,
	input  core_pkg::wb_t i_req_alu1,
	output logic          o_grant_agu,
	output logic          o_grant_alu0,
	output logic          o_grant_alu1,
	output core_pkg::wb_t o_wb
);

	// agu first so a load never waits on the ALUs
	assign o_grant_agu  = i_req_agu.valid;
	assign o_grant_alu0 = i_req_alu0.valid && !i_req_agu.valid;
	assign o_grant_alu1 = i_req_alu1.valid && !i_req_agu.valid && !i_req_alu0.valid;

	always_comb begin
		if (o_grant_agu) begin
			o_wb = i_req_agu;
		end else if (o_grant_alu0) begin
			o_wb = i_req_alu0;
		end else if (o_grant_alu1) begin
			o_wb = i_req_alu1;
		end else begin
			o_wb = '0;
		end
	end

endmodule

//--- tb_core.sv
module tb_core;
	import core_pkg::*;

	localparam int DMEM_ADDR_W = 14;
	// rough cycle budget of each test
	localparam int LEN_RESET = 12;
	localparam int LEN_ALU   = 70;
	localparam int LEN_ZERO  = 20;
	localparam int LEN_MEM   = 50;
	localparam int LEN_CONT  = 20;
	localparam int LEN_BUSY  = 50;
	localparam int CYCLE_LIMIT =
		(LEN_RESET + LEN_ALU + LEN_ZERO + LEN_MEM + LEN_CONT + LEN_BUSY) * 4;

	logic        i_clk;
	logic        i_rst_n;
	issue_t      i_issue;
	logic        o_busy;
	dmem_req_t   o_dmem;
	logic [31:0] i_dmem_rdata;
	wb_t         o_wb;

	logic [31:0] mem_model [256];
	logic [31:0] next_rdata;
	logic [31:0] regs [NUM_PRD];
	logic [31:0] lfsr;
	wb_t         wb_log [$];
	int          wb_cyc [$];
	dmem_req_t   dm_log [$];
	int          dm_cyc [$];
	wb_t         exp_q [$];
	int          wb_rd;
	int          dm_rd;
	int          cycle = 0;
	int          accept_cycle;
	logic        busy_seen;
	string       cur_test;
	int          test_errs;
	int          tests_pass;
	int          tests_fail;

	core #(
		.DMEM_ADDR_W (DMEM_ADDR_W)
	) dut0 (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_issue      (i_issue),
		.o_busy       (o_busy),
		.o_dmem       (o_dmem),
		.i_dmem_rdata (i_dmem_rdata),
		.o_wb         (o_wb)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// log of the writeback bus and of stores, sampled mid-cycle
	always @(negedge i_clk) begin
		if (i_rst_n && o_wb.valid) begin
			wb_log.push_back(o_wb);
			wb_cyc.push_back(cycle);
		end
		if (i_rst_n && o_dmem.we) begin
			dm_log.push_back(o_dmem);
			dm_cyc.push_back(cycle);
		end
	end

	// word memory, load data one cycle after the address
	initial begin
		for (int i = 0; i < 256; i++) begin
			mem_model[8'(i)] = 32'h3c00_0000 ^ (32'(i) * 32'h0001_0203);
		end
		next_rdata   = '0;
		i_dmem_rdata = '0;
		forever begin
			@(negedge i_clk);
			next_rdata = mem_model[o_dmem.addr[9:2]];
			if (i_rst_n && o_dmem.we) begin
				mem_model[o_dmem.addr[9:2]] = o_dmem.wdata;
			end
			@(posedge i_clk);
			#5;
			i_dmem_rdata = next_rdata;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] alu_expect(uop_e op, logic [31:0] a, logic [31:0] b,
			logic [31:0] imm);
		case (op)
			UOP_ADD: return a + b;
			UOP_SUB: return a - b;
			UOP_AND: return a & b;
			UOP_OR:  return a | b;
			UOP_XOR: return a ^ b;
			UOP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			UOP_SLL: return a << b[4:0];
			UOP_SRL: return a >> b[4:0];
			default: return imm;
		endcase
	endfunction

	function automatic wb_t make_wb(prd_t prd, logic [31:0] data);
		wb_t w;
		w.valid = 1'b1;
		w.prd   = prd;
		w.data  = data;
		return w;
	endfunction

	task automatic check_wb(string what, wb_t exp, wb_t act);
		if (exp !== act) begin
			$display("[FAIL] %s %s: expected valid=%b prd=%0d data=%h, actual valid=%b prd=%0d data=%h",
				cur_test, what, exp.valid, exp.prd, exp.data, act.valid, act.prd, act.data);
			test_errs++;
		end
	endtask

	task automatic check_dmem(string what, dmem_req_t exp, dmem_req_t act);
		if (exp !== act) begin
			$display("[FAIL] %s %s: expected we=%b addr=%h wdata=%h, actual we=%b addr=%h wdata=%h",
				cur_test, what, exp.we, exp.addr, exp.wdata, act.we, act.addr, act.wdata);
			test_errs++;
		end
	endtask

	task automatic expect_int(string what, int exp, int act);
		if (exp != act) begin
			$display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic start_test(string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic report_test();
		if (test_errs == 0) begin
			$display("test %s: passed", cur_test);
			tests_pass++;
		end else begin
			$display("test %s: failed with %0d mismatches", cur_test, test_errs);
			tests_fail++;
		end
	endtask

	task automatic idle(int n);
		repeat (n) begin
			@(posedge i_clk);
			#5;
		end
	endtask

	// holds the packet while busy, returns just after the accepting edge
	task automatic issue_uop(uop_e uop, prd_t prd, prd_t rs1, prd_t rs2, logic [31:0] imm);
		i_issue.valid = 1'b1;
		i_issue.uop   = uop;
		i_issue.prd   = prd;
		i_issue.prs1  = rs1;
		i_issue.prs2  = rs2;
		i_issue.imm   = imm;
		@(negedge i_clk);
		while (o_busy) begin
			busy_seen = 1'b1;
			@(negedge i_clk);
		end
		@(posedge i_clk);
		#5;
		accept_cycle  = cycle;
		i_issue.valid = 1'b0;
	endtask

	task automatic next_wb(output wb_t w, output int c);
		while (wb_log.size() <= wb_rd) begin
			@(posedge i_clk);
			#5;
		end
		w = wb_log[wb_rd];
		c = wb_cyc[wb_rd];
		wb_rd++;
	endtask

	task automatic run_alu(uop_e uop, prd_t prd, prd_t rs1, prd_t rs2, logic [31:0] imm);
		wb_t exp;
		wb_t got;
		int  c;
		exp = make_wb(prd, alu_expect(uop, regs[rs1], regs[rs2], imm));
		issue_uop(uop, prd, rs1, rs2, imm);
		next_wb(got, c);
		check_wb(uop.name(), exp, got);
		expect_int({uop.name(), " latency"}, 1, c - accept_cycle);
		if (prd != '0) begin
			regs[prd] = exp.data;
		end
	endtask

	// every queued result exactly once, nothing extra afterwards
	task automatic match_all(output wb_t first);
		wb_t got;
		wb_t got_q [$];
		int  c;
		int  hits;
		for (int n = 0; n < exp_q.size(); n++) begin
			next_wb(got, c);
			got_q.push_back(got);
		end
		foreach (exp_q[k]) begin
			hits = 0;
			foreach (got_q[j]) begin
				if (got_q[j] === exp_q[k]) begin
					hits++;
				end
			end
			expect_int($sformatf("writebacks to p%0d", exp_q[k].prd), 1, hits);
			regs[exp_q[k].prd] = exp_q[k].data;
		end
		idle(4);
		expect_int("extra writebacks", 0, wb_log.size() - wb_rd);
		first = got_q[0];
	endtask

	task automatic reset_state();
		start_test("reset_state");
		@(negedge i_clk);
		expect_int("wb valid", 0, int'(o_wb.valid));
		expect_int("dmem we", 0, int'(o_dmem.we));
		expect_int("busy", 0, int'(o_busy));
		expect_int("logged writebacks", 0, wb_log.size());
		@(posedge i_clk);
		#5;
		report_test();
	endtask

	task automatic alu_ops();
		logic [31:0] v;
		start_test("alu_ops");
		for (int i = 1; i <= 8; i++) begin
			rand_bits(32, v);
			run_alu(UOP_LI, prd_t'(i), '0, '0, v);
		end
		for (int i = 0; i < 8; i++) begin
			run_alu(uop_e'(4'(i)), prd_t'(16 + i), prd_t'(1 + i), prd_t'(8 - i), '0);
		end
		report_test();
	endtask

	task automatic reg_zero();
		start_test("reg_zero");
		run_alu(UOP_LI, '0, '0, '0, 32'h1234_5678);
		run_alu(UOP_ADD, 7'd20, '0, '0, '0);
		run_alu(UOP_OR, 7'd21, '0, 7'd1, '0);
		run_alu(UOP_SUB, 7'd22, 7'd2, '0, '0);
		report_test();
	endtask

	task automatic store_load();
		logic [31:0] imm;
		dmem_req_t   exp_d;
		wb_t         got;
		int          c;
		start_test("store_load");
		for (int i = 0; i < 3; i++) begin
			rand_bits(12, imm);
			exp_d.we    = 1'b1;
			exp_d.addr  = (regs[prd_t'(1 + i)] + imm) & ((32'd1 << DMEM_ADDR_W) - 32'd1);
			exp_d.wdata = regs[prd_t'(5 + i)];
			issue_uop(UOP_SW, '0, prd_t'(1 + i), prd_t'(5 + i), imm);
			idle(3);
			expect_int("store requests", 1, dm_log.size() - dm_rd);
			if (dm_log.size() > dm_rd) begin
				check_dmem("store", exp_d, dm_log[dm_rd]);
				expect_int("store cycle", accept_cycle, dm_cyc[dm_rd]);
				dm_rd = dm_log.size();
			end
			expect_int("store writebacks", 0, wb_log.size() - wb_rd);
			issue_uop(UOP_LW, prd_t'(40 + i), prd_t'(1 + i), '0, imm);
			next_wb(got, c);
			check_wb("load", make_wb(prd_t'(40 + i), exp_d.wdata), got);
			expect_int("load latency", 2, c - accept_cycle);
			regs[prd_t'(40 + i)] = exp_d.wdata;
		end
		expect_int("stray stores", 0, dm_log.size() - dm_rd);
		report_test();
	endtask

	task automatic wb_contention();
		wb_t first;
		start_test("wb_contention");
		exp_q.delete();
		exp_q.push_back(make_wb(7'd50, mem_model[8'h10]));
		exp_q.push_back(make_wb(7'd51, regs[7'd3] + regs[7'd4]));
		exp_q.push_back(make_wb(7'd52, regs[7'd5] - regs[7'd6]));
		issue_uop(UOP_LW, 7'd50, '0, '0, 32'h40);
		issue_uop(UOP_ADD, 7'd51, 7'd3, 7'd4, '0);
		issue_uop(UOP_SUB, 7'd52, 7'd5, 7'd6, '0);
		match_all(first);
		// load and ADD are ready in the same cycle
		check_wb("first writeback", exp_q[0], first);
		report_test();
	endtask

	task automatic busy_hold();
		wb_t first;
		prd_t p;
		start_test("busy_hold");
		exp_q.delete();
		busy_seen = 1'b0;
		for (int i = 0; i < 4; i++) begin
			p = prd_t'(60 + 2 * i);
			exp_q.push_back(make_wb(p, mem_model[8'(20 + 2 * i)]));
			exp_q.push_back(make_wb(p + 7'd1, mem_model[8'(21 + 2 * i)]));
			issue_uop(UOP_LW, p, '0, '0, 32'(80 + 8 * i));
			issue_uop(UOP_LW, p + 7'd1, '0, '0, 32'(84 + 8 * i));
			p = prd_t'(70 + 2 * i);
			exp_q.push_back(make_wb(p, regs[prd_t'(1 + i)] + regs[prd_t'(2 + i)]));
			exp_q.push_back(make_wb(p + 7'd1, regs[prd_t'(3 + i)] ^ regs[prd_t'(4 + i)]));
			issue_uop(UOP_ADD, p, prd_t'(1 + i), prd_t'(2 + i), '0);
			issue_uop(UOP_XOR, p + 7'd1, prd_t'(3 + i), prd_t'(4 + i), '0);
		end
		match_all(first);
		expect_int("busy raised", 1, int'(busy_seen));
		report_test();
	endtask

	initial begin
		i_rst_n    = 1'b0;
		i_issue    = '0;
		lfsr       = 32'h14ba_98c3;
		regs[0]    = '0;
		wb_rd      = 0;
		dm_rd      = 0;
		busy_seen  = 1'b0;
		tests_pass = 0;
		tests_fail = 0;
		repeat (8) @(posedge i_clk);
		#5;
		i_rst_n = 1'b1;
		reset_state();
		alu_ops();
		reg_zero();
		store_load();
		wb_contention();
		busy_hold();
		$display("tests passed: %0d, failed: %0d", tests_pass, tests_fail);
		if (tests_fail == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
